//--- periph_bus_pkg.sv
// APB bus widths, the data word and the two-view address word.
// Shared by every block on the peripheral bus.
package periph_bus_pkg;

    localparam int ApbAddrW = 32;
    localparam int ApbDataW = 32;

    typedef logic [ApbDataW-1:0] apb_data_t;

    // ------------------------------------------------------------
    // Address word, decoded per target block
    // ------------------------------------------------------------
    typedef union packed {
        // Timer region carries a timer index above the register index
        struct packed {
            logic [ApbAddrW-17:0] pad_hi;
            logic [3:0]           region;
            logic [5:0]           pad_mid;
            logic [1:0]           timer_idx;
            logic [1:0]           reg_idx;
            logic [1:0]           pad_lo;
        } timer_view;
        // Interrupt region has a flat register file
        struct packed {
            logic [ApbAddrW-17:0] pad_hi;
            logic [3:0]           region;
            logic [7:0]           pad_mid;
            logic [1:0]           reg_idx;
            logic [1:0]           pad_lo;
        } irq_view;
    } apb_addr_u;

endpackage

//--- periph_map_pkg.sv
// Address map of the peripheral subsystem.
// Region codes, register indices and the error response word.
package periph_map_pkg;

    // Region codes, all others are unmapped
    localparam logic [3:0] RegionIrq   = 4'd0;
    localparam logic [3:0] RegionTimer = 4'd1;

    // Timers, one interrupt source each
    localparam int NumTimers = 2;

    // Timer registers
    localparam logic [1:0] TimerRegCtrl    = 2'd0;
    localparam logic [1:0] TimerRegCount   = 2'd1;
    localparam logic [1:0] TimerRegCompare = 2'd2;

    // Interrupt gate registers
    localparam logic [1:0] IrqRegPending = 2'd0;
    localparam logic [1:0] IrqRegEnable  = 2'd1;

    // Read data for any failed access
    localparam logic [31:0] ErrorData = 32'hdeadbeef;

    typedef enum logic [1:0] {
        TGT_NONE,
        TGT_TIMER,
        TGT_IRQ
    } tgt_e;

endpackage

//--- apb_decode.sv
// Address decode for the APB completer.
// Picks the target block, register and timer and flags unmapped accesses.
module apb_decode
    import periph_bus_pkg::*;
    import periph_map_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  logic      psel_i,
    input  logic      penable_i,
    input  logic      pwrite_i,
    input  apb_addr_u paddr_i,
    output tgt_e      tgt_o,
    output logic [1:0] reg_idx_o,
    output logic      timer_idx_o,
    output logic      err_o,
    output logic      wr_o
);

    always_comb begin
        // Unmapped unless a region below claims the address
        tgt_o       = TGT_NONE;
        // Register index sits at the same bits in both views
        reg_idx_o   = paddr_i.irq_view.reg_idx;
        timer_idx_o = 1'b0;
        err_o       = 1'b1;

        case (paddr_i.timer_view.region)
            RegionTimer: begin
                tgt_o       = TGT_TIMER;
                timer_idx_o = paddr_i.timer_view.timer_idx[0];
                err_o       = (paddr_i.timer_view.timer_idx >= NumTimers) ||
                              (paddr_i.timer_view.reg_idx > TimerRegCompare);
            end
            RegionIrq: begin
                tgt_o = TGT_IRQ;
                err_o = paddr_i.irq_view.reg_idx > IrqRegEnable;
            end
            default: begin
                tgt_o = TGT_NONE;
            end
        endcase
    end

    // Registers update at the end of the access cycle
    assign wr_o = psel_i && penable_i && pwrite_i && !err_o;

    // ------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------
    // An address that errors in setup never strobes a write in the access cycle
    err_no_write_a: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        psel_i && !penable_i && err_o |=> !wr_o
    ) else $error("write strobe raised on an erroring access");

endmodule

//--- timer_bank.sv
// Bank of compare timers with ctrl, count and compare registers.
// Each timer raises a sticky expired flag that feeds the interrupt gate.
module timer_bank
    import periph_bus_pkg::*;
    import periph_map_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 wr_i,
    input  logic [1:0]           reg_idx_i,
    input  logic                 timer_idx_i,
    input  apb_data_t            wdata_i,
    output apb_data_t            rdata_o,
    output logic [NumTimers-1:0] expired_o
);

    logic [NumTimers-1:0] en_q;
    logic [NumTimers-1:0] expired_q;
    apb_data_t            count_q   [NumTimers];
    apb_data_t            compare_q [NumTimers];

    logic [NumTimers-1:0] wr_sel;
    logic [NumTimers-1:0] hit;

    // Per timer write select and compare match
    always_comb begin
        for (int i = 0; i < NumTimers; i++) begin
            wr_sel[i] = wr_i && (timer_idx_i == i);
            // Also catches a compare moved below the running count
            hit[i]    = en_q[i] && (count_q[i] >= compare_q[i]);
        end
    end

    // ------------------------------------------------------------
    // Timer registers
    // ------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            en_q      <= '0;
            expired_q <= '0;
            for (int i = 0; i < NumTimers; i++) begin
                count_q[i]   <= '0;
                compare_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NumTimers; i++) begin
                if (wr_sel[i] && reg_idx_i == TimerRegCount) begin
                    count_q[i] <= wdata_i;
                end else if (hit[i]) begin
                    count_q[i] <= '0;
                end else if (en_q[i]) begin
                    count_q[i] <= count_q[i] + 1'b1;
                end

                if (wr_sel[i] && reg_idx_i == TimerRegCompare) begin
                    compare_q[i] <= wdata_i;
                end

                if (wr_sel[i] && reg_idx_i == TimerRegCtrl) begin
                    en_q[i] <= wdata_i[0];
                end

                // Set on match wins over a clear in the same cycle
                if (hit[i]) begin
                    expired_q[i] <= 1'b1;
                end else if (wr_sel[i] && reg_idx_i == TimerRegCtrl && wdata_i[1]) begin
                    expired_q[i] <= 1'b0;
                end
            end
        end
    end

    always_comb begin
        case (reg_idx_i)
            TimerRegCtrl: begin
                rdata_o = {{(ApbDataW-2){1'b0}}, expired_q[timer_idx_i], en_q[timer_idx_i]};
            end
            TimerRegCount:   rdata_o = count_q[timer_idx_i];
            TimerRegCompare: rdata_o = compare_q[timer_idx_i];
            default:         rdata_o = '0;
        endcase
    end

    assign expired_o = expired_q;

    // Settled running count stays within compare
    for (genvar g = 0; g < NumTimers; g++) begin : gen_chk
        count_bound_a: assert property (
            @(posedge clk_i) disable iff (!rst_n_i)
            en_q[g] && $past(en_q[g]) && !$past(wr_sel[g]) |-> count_q[g] <= compare_q[g]
        ) else $error("timer %0d count above compare", g);
    end

endmodule

//--- irq_gate.sv
// Interrupt gate for the timer sources.
// Masks the raw lines with the enable register and drives one registered irq.
module irq_gate
    import periph_bus_pkg::*;
    import periph_map_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 wr_i,
    input  logic [1:0]           reg_idx_i,
    input  apb_data_t            wdata_i,
    input  logic [NumTimers-1:0] src_i,
    output apb_data_t            rdata_o,
    output logic                 irq_o
);

    logic [NumTimers-1:0] enable_q;
    logic                 irq_q;

    // ------------------------------------------------------------
    // Enable mask and combined interrupt
    // ------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            enable_q <= '0;
            irq_q    <= 1'b0;
        end else begin
            if (wr_i && reg_idx_i == IrqRegEnable) begin
                enable_q <= wdata_i[NumTimers-1:0];
            end
            // One cycle behind the source level
            irq_q <= |(src_i & enable_q);
        end
    end

    // Pending shows raw levels, writes to it are dropped
    always_comb begin
        case (reg_idx_i)
            IrqRegPending: rdata_o = {{(ApbDataW-NumTimers){1'b0}}, src_i};
            IrqRegEnable:  rdata_o = {{(ApbDataW-NumTimers){1'b0}}, enable_q};
            default:       rdata_o = '0;
        endcase
    end

    assign irq_o = irq_q;

endmodule

//--- apb_response.sv
// Access-phase response of the APB completer.
// Muxes read data by target and flags errors with pslverr.
module apb_response
    import periph_bus_pkg::*;
    import periph_map_pkg::*;
(
    input  logic      psel_i,
    input  logic      penable_i,
    input  tgt_e      tgt_i,
    input  logic      err_i,
    input  apb_data_t timer_rdata_i,
    input  apb_data_t irq_rdata_i,
    output apb_data_t prdata_o,
    output logic      pready_o,
    output logic      pslverr_o
);

    // Zero wait states, every access cycle completes
    assign pready_o  = psel_i && penable_i;
    assign pslverr_o = pready_o && err_i;

    always_comb begin
        if (err_i) begin
            prdata_o = ErrorData;
        end else begin
            case (tgt_i)
                TGT_TIMER: prdata_o = timer_rdata_i;
                TGT_IRQ:   prdata_o = irq_rdata_i;
                default:   prdata_o = ErrorData;
            endcase
        end
    end

    // ------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------
    // Unmapped target always arrives with the error flag from decode
    always_comb begin
        tgt_err_a: assert (tgt_i != TGT_NONE || err_i)
            else $error("unmapped target without error flag");
    end

endmodule

//--- periph_subsys.sv
// Top of the APB peripheral subsystem with two timers and an interrupt gate.
// Single APB completer with zero wait states and one interrupt output.
module periph_subsys
    import periph_bus_pkg::*;
    import periph_map_pkg::*;
(
    input  logic                clk_i,
    input  logic                rst_n_i,
    // APB completer
    input  logic                psel_i,
    input  logic                penable_i,
    input  logic                pwrite_i,
    input  logic [ApbAddrW-1:0] paddr_i,
    input  apb_data_t           pwdata_i,
    output apb_data_t           prdata_o,
    output logic                pready_o,
    output logic                pslverr_o,
    // Combined timer interrupt
    output logic                irq_o
);

    tgt_e                 tgt;
    logic [1:0]           reg_idx;
    logic                 timer_idx;
    logic                 err;
    logic                 wr;
    logic                 timer_wr;
    logic                 irq_wr;
    apb_data_t            timer_rdata;
    apb_data_t            irq_rdata;
    logic [NumTimers-1:0] expired;

    // ------------------------------------------------------------
    // Decode
    // ------------------------------------------------------------
    apb_decode u_decode (
        .clk_i       ( clk_i     ),
        .rst_n_i     ( rst_n_i   ),
        .psel_i      ( psel_i    ),
        .penable_i   ( penable_i ),
        .pwrite_i    ( pwrite_i  ),
        .paddr_i     ( paddr_i   ),
        .tgt_o       ( tgt       ),
        .reg_idx_o   ( reg_idx   ),
        .timer_idx_o ( timer_idx ),
        .err_o       ( err       ),
        .wr_o        ( wr        )
    );

    // Write strobe per target block
    assign timer_wr = wr && (tgt == TGT_TIMER);
    assign irq_wr   = wr && (tgt == TGT_IRQ);

    // ------------------------------------------------------------
    // Timers and interrupt gate
    // ------------------------------------------------------------
    timer_bank u_timer (
        .clk_i       ( clk_i       ),
        .rst_n_i     ( rst_n_i     ),
        .wr_i        ( timer_wr    ),
        .reg_idx_i   ( reg_idx     ),
        .timer_idx_i ( timer_idx   ),
        .wdata_i     ( pwdata_i    ),
        .rdata_o     ( timer_rdata ),
        .expired_o   ( expired     )
    );

    irq_gate u_irq (
        .clk_i     ( clk_i     ),
        .rst_n_i   ( rst_n_i   ),
        .wr_i      ( irq_wr    ),
        .reg_idx_i ( reg_idx   ),
        .wdata_i   ( pwdata_i  ),
        .src_i     ( expired   ),
        .rdata_o   ( irq_rdata ),
        .irq_o     ( irq_o     )
    );

    // Response
    apb_response u_resp (
        .psel_i        ( psel_i      ),
        .penable_i     ( penable_i   ),
        .tgt_i         ( tgt         ),
        .err_i         ( err         ),
        .timer_rdata_i ( timer_rdata ),
        .irq_rdata_i   ( irq_rdata   ),
        .prdata_o      ( prdata_o    ),
        .pready_o      ( pready_o    ),
        .pslverr_o     ( pslverr_o   )
    );

endmodule

//--- tb_periph_subsys.sv
// Self-checking testbench for the APB peripheral subsystem.
// Applies a register access table, then exercises timer expiry and the interrupt gate.
module tb_periph_subsys
    import periph_bus_pkg::*;
    import periph_map_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    typedef struct packed {
        logic        wr;
        logic [31:0] addr;
        apb_data_t   wdata;
        apb_data_t   exp_rdata;
        logic        exp_err;
    } access_t;

    logic        clk;
    logic        rst_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] paddr;
    apb_data_t   pwdata;
    apb_data_t   prdata;
    logic        pready;
    logic        pslverr;
    logic        irq;

    access_t     table_q[$];
    logic        table_ready = 1'b0;
    integer      seed = 32'h9141d65e;
    apb_data_t   rand_val[4];

    periph_subsys dut_i (
        .clk_i     ( clk     ),
        .rst_n_i   ( rst_n   ),
        .psel_i    ( psel    ),
        .penable_i ( penable ),
        .pwrite_i  ( pwrite  ),
        .paddr_i   ( paddr   ),
        .pwdata_i  ( pwdata  ),
        .prdata_o  ( prdata  ),
        .pready_o  ( pready  ),
        .pslverr_o ( pslverr ),
        .irq_o     ( irq     )
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // ------------------------------------------------------------
    // Compare tasks and address helpers
    // ------------------------------------------------------------
    task automatic check_data(input string name, input apb_data_t got, input apb_data_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, got);
            $display("sim failed");
            $fatal(1, "stopping on first mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s expected %b, got %b", $time, name, exp, got);
            $display("sim failed");
            $fatal(1, "stopping on first mismatch");
        end
    endtask

    function automatic logic [31:0] timer_addr(input logic [1:0] t, input logic [1:0] r);
        return {16'h0, RegionTimer, 6'h0, t, r, 2'b00};
    endfunction

    function automatic logic [31:0] irq_addr(input logic [1:0] r);
        return {16'h0, RegionIrq, 8'h0, r, 2'b00};
    endfunction

    function automatic logic [31:0] region_addr(input logic [3:0] region);
        return {16'h0, region, 12'h0};
    endfunction

    // Setup then access cycle, starting and ending on a falling edge
    task automatic apb_access(input logic wr, input logic [31:0] addr, input apb_data_t wdata,
                              output apb_data_t rdata, output logic err);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        #10;
        rdata = prdata;
        err   = pslverr;
        check_flag("pready_o", pready, 1'b1);
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic write_reg(input logic [31:0] addr, input apb_data_t wdata);
        apb_data_t rdata;
        logic      err;
        apb_access(1'b1, addr, wdata, rdata, err);
        check_flag("pslverr_o", err, 1'b0);
    endtask

    task automatic read_reg(input logic [31:0] addr, output apb_data_t rdata);
        logic err;
        apb_access(1'b0, addr, '0, rdata, err);
        check_flag("pslverr_o", err, 1'b0);
    endtask

    task automatic wait_irq(input logic level, input int max_cycles);
        int n;
        n = 0;
        while (irq !== level && n < max_cycles) begin
            @(negedge clk);
            n++;
        end
        if (irq !== level) begin
            $display("irq_o did not reach %b within %0d cycles", level, max_cycles);
            $display("sim failed");
            $fatal(1, "interrupt timeout");
        end
    endtask

    task automatic add_entry(input logic wr, input logic [31:0] addr, input apb_data_t wdata,
                             input apb_data_t exp_rdata, input logic exp_err);
        access_t e;
        e.wr        = wr;
        e.addr      = addr;
        e.wdata     = wdata;
        e.exp_rdata = exp_rdata;
        e.exp_err   = exp_err;
        table_q.push_back(e);
    endtask

    // ------------------------------------------------------------
    // Access table
    // ------------------------------------------------------------
    task automatic build_table();
        for (int i = 0; i < 4; i++) begin
            rand_val[i] = $random(seed);
        end
        // Reset values of every mapped register
        for (int t = 0; t < NumTimers; t++) begin
            add_entry(1'b0, timer_addr(t, TimerRegCtrl), '0, '0, 1'b0);
            add_entry(1'b0, timer_addr(t, TimerRegCount), '0, '0, 1'b0);
            add_entry(1'b0, timer_addr(t, TimerRegCompare), '0, '0, 1'b0);
        end
        add_entry(1'b0, irq_addr(IrqRegPending), '0, '0, 1'b0);
        add_entry(1'b0, irq_addr(IrqRegEnable), '0, '0, 1'b0);
        // Write and read back, timers still disabled
        for (int t = 0; t < NumTimers; t++) begin
            add_entry(1'b1, timer_addr(t, TimerRegCompare), rand_val[2*t], '0, 1'b0);
            add_entry(1'b0, timer_addr(t, TimerRegCompare), '0, rand_val[2*t], 1'b0);
            add_entry(1'b1, timer_addr(t, TimerRegCount), rand_val[2*t+1], '0, 1'b0);
            add_entry(1'b0, timer_addr(t, TimerRegCount), '0, rand_val[2*t+1], 1'b0);
        end
        // Unmapped regions, timer index and register index
        add_entry(1'b1, region_addr(4'h2), 32'h1234_5678, '0, 1'b1);
        add_entry(1'b0, region_addr(4'h2), '0, ErrorData, 1'b1);
        add_entry(1'b0, region_addr(4'hf), '0, ErrorData, 1'b1);
        add_entry(1'b1, timer_addr(2, TimerRegCompare), ~rand_val[0], '0, 1'b1);
        add_entry(1'b0, timer_addr(3, TimerRegCount), '0, ErrorData, 1'b1);
        add_entry(1'b1, timer_addr(3, TimerRegCount), ~rand_val[3], '0, 1'b1);
        add_entry(1'b1, timer_addr(0, 2'd3), 32'h1, '0, 1'b1);
        add_entry(1'b0, timer_addr(1, 2'd3), '0, ErrorData, 1'b1);
        add_entry(1'b1, irq_addr(2'd3), 32'h3, '0, 1'b1);
        add_entry(1'b0, irq_addr(2'd2), '0, ErrorData, 1'b1);
        // Registers behind the failed writes are untouched
        add_entry(1'b0, timer_addr(0, TimerRegCompare), '0, rand_val[0], 1'b0);
        add_entry(1'b0, timer_addr(1, TimerRegCount), '0, rand_val[3], 1'b0);
        add_entry(1'b0, timer_addr(0, TimerRegCtrl), '0, '0, 1'b0);
        add_entry(1'b0, irq_addr(IrqRegEnable), '0, '0, 1'b0);
    endtask

    // Watchdog sized from the table
    initial begin
        wait (table_ready);
        repeat (table_q.size() * 4 + 2000) @(posedge clk);
        $display("Timeout: the run did not finish in time");
        $display("sim failed");
        $fatal(1, "watchdog expired");
    end

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------
    initial begin
        apb_data_t rdata;
        apb_data_t c1;
        logic      err;
        int        n;

        rst_n   = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        build_table();
        table_ready = 1'b1;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_flag("irq_o", irq, 1'b0);
        check_flag("pslverr_o", pslverr, 1'b0);

        foreach (table_q[i]) begin
            apb_access(table_q[i].wr, table_q[i].addr, table_q[i].wdata, rdata, err);
            check_flag("pslverr_o", err, table_q[i].exp_err);
            if (!table_q[i].wr) begin
                check_data("prdata_o", rdata, table_q[i].exp_rdata);
            end
        end

        // Timer 0 expiry raises irq, clearing the flag drops it
        write_reg(timer_addr(0, TimerRegCount), '0);
        write_reg(timer_addr(0, TimerRegCompare), 32'd20);
        write_reg(irq_addr(IrqRegEnable), 32'h1);
        write_reg(timer_addr(0, TimerRegCtrl), 32'h1);
        wait_irq(1'b1, 30);
        read_reg(timer_addr(0, TimerRegCtrl), rdata);
        check_data("timer0 ctrl", rdata, 32'h3);
        read_reg(irq_addr(IrqRegPending), rdata);
        check_data("irq pending", rdata, 32'h1);
        write_reg(timer_addr(0, TimerRegCtrl), 32'h2);
        wait_irq(1'b0, 4);

        // Timer 1 is masked off in the gate
        write_reg(timer_addr(1, TimerRegCount), '0);
        write_reg(timer_addr(1, TimerRegCompare), 32'd10);
        write_reg(timer_addr(1, TimerRegCtrl), 32'h1);
        n     = 0;
        rdata = '0;
        while (!rdata[1] && n < 20) begin
            read_reg(irq_addr(IrqRegPending), rdata);
            check_flag("irq_o", irq, 1'b0);
            n++;
        end
        if (!rdata[1]) begin
            $display("timer 1 never showed up in the pending register");
            $display("sim failed");
            $fatal(1, "pending timeout");
        end
        check_data("irq pending", rdata, 32'h2);
        repeat (3) @(negedge clk);
        check_flag("irq_o", irq, 1'b0);
        write_reg(timer_addr(1, TimerRegCtrl), 32'h2);

        // Count wraps at compare while running, then holds once stopped
        write_reg(timer_addr(0, TimerRegCount), '0);
        write_reg(timer_addr(0, TimerRegCompare), 32'd50);
        write_reg(timer_addr(0, TimerRegCtrl), 32'h1);
        repeat (70) @(negedge clk);
        write_reg(timer_addr(0, TimerRegCtrl), 32'h0);
        read_reg(timer_addr(0, TimerRegCount), c1);
        if (c1 > 32'd50) begin
            $display("timer 0 count %0d ran past its compare value of 50", c1);
            $display("sim failed");
            $fatal(1, "count above compare");
        end
        read_reg(timer_addr(0, TimerRegCount), rdata);
        check_data("timer0 count", rdata, c1);
        read_reg(timer_addr(0, TimerRegCount), rdata);
        check_data("timer0 count", rdata, c1);

        $display("sim passed");
        $finish;
    end

endmodule

//--- flist.f
periph_bus_pkg.sv
periph_map_pkg.sv
apb_decode.sv
timer_bank.sv
irq_gate.sv
apb_response.sv
periph_subsys.sv
tb_periph_subsys.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_periph_subsys
FLIST     = flist.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)

run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "sim failed" $(LOG); then echo "RESULT: FAIL"; exit 1; fi
	@if ! grep -q "sim passed" $(LOG); then echo "RESULT: FAIL"; exit 1; fi
	@echo "RESULT: PASS"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
